//--- common/cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

////////////////////////////////////////
// Machine geometry
////////////////////////////////////////
`define DATA_WIDTH    16 // Machine word
`define REG_ADDR_BITS 4  // Sixteen registers
`define MEM_ADDR_BITS 10 // 1024 memory words

`endif

//--- common/CpuIsaPkg.sv
`include "cpu_macros.svh"

package CpuIsaPkg;

    // Opcode nibble, value equals the ALU control code
    typedef enum logic [3:0] {
        ADD = 4'h0, SUB = 4'h1, XOR = 4'h2, RED = 4'h3,
        SLL = 4'h4, SRA = 4'h5, ROR = 4'h6, PADDSB = 4'h7,
        LW = 4'h8, SW = 4'h9, LLB = 4'hA, LHB = 4'hB,
        B = 4'hC, BR = 4'hD, PCS = 4'hE, HLT = 4'hF
    } opcodeE;

    ////////////////////////////////////////
    // Instruction word views
    ////////////////////////////////////////
    typedef struct packed {
        opcodeE                   op;
        logic [`REG_ADDR_BITS-1:0] rd;
        logic [`REG_ADDR_BITS-1:0] rs;
        logic [`REG_ADDR_BITS-1:0] rt;
    } rTypeS;

    typedef struct packed {
        opcodeE                   op;
        logic [`REG_ADDR_BITS-1:0] rd;
        logic [`REG_ADDR_BITS-1:0] rs;
        logic [3:0]               imm4; // Shift count or memory offset
    } immTypeS;

    typedef struct packed {
        opcodeE                   op;
        logic [`REG_ADDR_BITS-1:0] rd;
        logic [7:0]               imm8; // LLB and LHB byte
    } byteTypeS;

    typedef struct packed {
        opcodeE     op;
        logic [2:0] cond; // Condition code
        logic [8:0] imm9; // Signed word offset for B
    } brTypeS;

    // Same 16 bits, decoded per opcode
    typedef union packed {
        rTypeS    rType;
        immTypeS  immType;
        byteTypeS byteType;
        brTypeS   brType;
    } instrU;

    // ControlUnit outputs
    typedef struct packed {
        logic   aluSrc;    // Immediate on ALU B input
        logic   memToReg;  // Load data to register file
        logic   regWrite;
        logic   regSrc;    // Port A reads rd instead of rs
        logic   memEnable; // LW or SW
        logic   memWrite;  // SW only
        logic   branch;    // B or BR
        logic   hlt;
        logic   pcs;
        opcodeE aluOp;
        logic   zEn;       // Z flag update
        logic   nvEn;      // N and V flag update
    } ctrlS;

    typedef struct packed {
        logic z;
        logic n;
        logic v;
    } flagsS;

endpackage

//--- common/CpuBusPkg.sv
`include "cpu_macros.svh"

package CpuBusPkg;

    ////////////////////////////////////////
    // Memory port request
    ////////////////////////////////////////
    // Level request, active while en is high
    // Read data comes back one cycle after grant
    typedef struct packed {
        logic                      en;    // Request active
        logic                      we;    // Write when set, else read
        logic [`MEM_ADDR_BITS-1:0] addr;  // Word address
        logic [`DATA_WIDTH-1:0]    wdata; // Write payload
    } memReqS;

endpackage

//--- core/ControlUnit.sv
module ControlUnit (
    input  CpuIsaPkg::opcodeE opcode,
    output CpuIsaPkg::ctrlS   ctrl
);
    import CpuIsaPkg::*;

    logic [3:0] op; // Raw nibble for the sum-of-products terms

    assign op = opcode;

    ////////////////////////////////////////
    // Opcode decode
    ////////////////////////////////////////
    // SLL, SRA, ROR, LW, SW, LLB, LHB take an immediate
    assign ctrl.aluSrc = op[3] | (op[2] & ~op[1]) | (op[2] & op[1] & ~op[0]);

    assign ctrl.memToReg = op[3] & ~op[1]; // LW result comes from memory

    // All ALU ops, LW, LLB, LHB and PCS
    assign ctrl.regWrite = ~op[3] | op[1] | (op[3] & ~op[2] & ~op[0]);

    assign ctrl.regSrc = op[3] & op[1]; // LLB and LHB merge into rd

    assign ctrl.memEnable = op[3] & ~op[2] & ~op[1];           // LW, SW
    assign ctrl.memWrite  = op[3] & ~op[2] & ~op[1] & op[0];   // SW
    assign ctrl.branch    = op[3] & op[2] & ~op[1];            // B, BR

    assign ctrl.hlt = (opcode == HLT);
    assign ctrl.pcs = (opcode == PCS);

    // ALU control is the opcode itself
    assign ctrl.aluOp = opcode;

    // Z follows every ALU op except RED and PADDSB
    assign ctrl.zEn = ~op[3] & (~op[1] | ~op[0]);

    // N and V only for ADD and SUB
    assign ctrl.nvEn = (op[3:1] == 3'b000);

endmodule

//--- core/RegisterFile.sv
`include "cpu_macros.svh"

module RegisterFile (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic [`REG_ADDR_BITS-1:0] rdAddrA,
    input  logic [`REG_ADDR_BITS-1:0] rdAddrB,
    input  logic [`REG_ADDR_BITS-1:0] wrAddr,
    input  logic                      wrEn,
    input  logic [`DATA_WIDTH-1:0]    wrData,
    output logic [`DATA_WIDTH-1:0]    rdDataA,
    output logic [`DATA_WIDTH-1:0]    rdDataB
);

    logic [`DATA_WIDTH-1:0] regs [1 << `REG_ADDR_BITS];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < (1 << `REG_ADDR_BITS); i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && (wrAddr != '0)) begin // R0 ignores writes
            regs[wrAddr] <= wrData;
        end
    end

    // Combinational reads, R0 always zero
    assign rdDataA = (rdAddrA == '0) ? '0 : regs[rdAddrA];
    assign rdDataB = (rdAddrB == '0) ? '0 : regs[rdAddrB];

endmodule

//--- core/Alu.sv
`include "cpu_macros.svh"

module Alu (
    input  CpuIsaPkg::opcodeE      aluOp,
    input  logic [`DATA_WIDTH-1:0] opA,
    input  logic [`DATA_WIDTH-1:0] opB,
    output logic [`DATA_WIDTH-1:0] result,
    output CpuIsaPkg::flagsS       flagsOut
);
    import CpuIsaPkg::*;

    logic [`DATA_WIDTH-1:0]   sum;
    logic [`DATA_WIDTH-1:0]   diff;
    logic [`DATA_WIDTH-1:0]   redSum;
    logic [`DATA_WIDTH-1:0]   paddsb;
    logic [2*`DATA_WIDTH-1:0] rotWide;
    logic                     addOvf;
    logic                     subOvf;

    assign sum  = opA + opB; // Also the LW/SW address
    assign diff = opA - opB;

    // Signed overflow when operand signs allow it and result sign flips
    assign addOvf = (opA[15] == opB[15]) && (sum[15] != opA[15]);
    assign subOvf = (opA[15] != opB[15]) && (diff[15] != opA[15]);

    // RED: four signed bytes summed
    assign redSum = {{8{opA[15]}}, opA[15:8]} + {{8{opA[7]}}, opA[7:0]}
                  + {{8{opB[15]}}, opB[15:8]} + {{8{opB[7]}}, opB[7:0]};

    assign rotWide = {opA, opA} >> opB[3:0]; // Rotate via doubled word

    ////////////////////////////////////////
    // PADDSB nibble lanes
    ////////////////////////////////////////
    always_comb begin
        logic signed [4:0] nibSum;
        paddsb = '0;
        for (int i = 0; i < 4; i++) begin
            nibSum = $signed({opA[4*i+3], opA[4*i +: 4]})
                   + $signed({opB[4*i+3], opB[4*i +: 4]});
            if (nibSum > 5'sd7)       paddsb[4*i +: 4] = 4'h7; // Clamp high
            else if (nibSum < -5'sd8) paddsb[4*i +: 4] = 4'h8; // Clamp low
            else                      paddsb[4*i +: 4] = nibSum[3:0];
        end
    end

    always_comb begin
        case (aluOp)
            SUB:     result = diff;
            XOR:     result = opA ^ opB;
            RED:     result = redSum;
            SLL:     result = opA << opB[3:0];
            SRA:     result = $signed(opA) >>> opB[3:0];
            ROR:     result = rotWide[`DATA_WIDTH-1:0];
            PADDSB:  result = paddsb;
            LLB:     result = {opA[15:8], opB[7:0]}; // Keep high byte of rd
            LHB:     result = {opB[7:0], opA[7:0]};  // Keep low byte of rd
            default: result = sum;                   // ADD, LW, SW
        endcase
    end

    // Candidates only, the core picks which flags latch
    assign flagsOut.z = (result == '0);
    assign flagsOut.n = result[`DATA_WIDTH-1];
    assign flagsOut.v = (aluOp == ADD) ? addOvf : (aluOp == SUB) ? subOvf : 1'b0;

endmodule

//--- core/CpuCore.sv
`include "cpu_macros.svh"

module CpuCore (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   start,
    output CpuBusPkg::memReqS      memReq,
    input  logic                   coreGnt,
    input  logic [`DATA_WIDTH-1:0] rdata,
    output logic                   halted
);
    import CpuIsaPkg::*;

    typedef enum logic [2:0] {IDLE, FETCH, EXEC, MEM, WB, HALT} stateE;

    stateE                     state;
    logic                      irPending;   // Fetch granted, instruction on rdata next
    instrU                     ir;
    flagsS                     flags;
    flagsS                     aluFlags;
    ctrlS                      ctrl;
    logic [`MEM_ADDR_BITS-1:0] pc;
    logic [`MEM_ADDR_BITS-1:0] pcPlus1;
    logic [`MEM_ADDR_BITS-1:0] branchTarget;
    logic [`DATA_WIDTH-1:0]    rdDataA;
    logic [`DATA_WIDTH-1:0]    rdDataB;
    logic [`DATA_WIDTH-1:0]    immExt;
    logic [`DATA_WIDTH-1:0]    aluB;
    logic [`DATA_WIDTH-1:0]    aluResult;
    logic [`DATA_WIDTH-1:0]    wrData;
    logic                      wrEn;
    logic                      condTrue;

    ControlUnit ctrlUnit (.opcode(ir.rType.op), .ctrl(ctrl));

    RegisterFile regFile (
        .clk     (clk),
        .rstN    (rstN),
        .rdAddrA (ctrl.regSrc ? ir.rType.rd : ir.rType.rs),
        .rdAddrB (ctrl.memWrite ? ir.rType.rd : ir.rType.rt), // SW stores rd
        .wrAddr  (ir.rType.rd),
        .wrEn    (wrEn),
        .wrData  (wrData),
        .rdDataA (rdDataA),
        .rdDataB (rdDataB)
    );

    // Byte immediate for LLB/LHB, else signed imm4
    assign immExt = ctrl.regSrc ? {{(`DATA_WIDTH-8){1'b0}}, ir.byteType.imm8}
                                : {{(`DATA_WIDTH-4){ir.immType.imm4[3]}}, ir.immType.imm4};
    assign aluB   = ctrl.aluSrc ? immExt : rdDataB;

    Alu alu (.aluOp(ctrl.aluOp), .opA(rdDataA), .opB(aluB),
             .result(aluResult), .flagsOut(aluFlags));

    ////////////////////////////////////////
    // Branch decision
    ////////////////////////////////////////
    always_comb begin
        case (ir.brType.cond)
            3'd0:    condTrue = ~flags.z;
            3'd1:    condTrue = flags.z;
            3'd2:    condTrue = ~flags.z & ~flags.n;
            3'd3:    condTrue = flags.n;
            3'd4:    condTrue = flags.z | (~flags.n & ~flags.v);
            3'd5:    condTrue = flags.z | flags.n;
            3'd6:    condTrue = flags.v;
            default: condTrue = 1'b1; // Unconditional
        endcase
    end

    assign pcPlus1      = pc + 1'b1;
    assign branchTarget = (ir.rType.op == B)
        ? pcPlus1 + {{(`MEM_ADDR_BITS-9){ir.brType.imm9[8]}}, ir.brType.imm9}
        : rdDataA[`MEM_ADDR_BITS-1:0]; // BR jumps to rs

    // Writeback: ALU ops in EXEC, LW in WB
    assign wrEn = ((state == EXEC) && ctrl.regWrite && !ctrl.memEnable && !ctrl.hlt)
               || ((state == WB) && ctrl.regWrite && ctrl.memToReg);
    assign wrData = ctrl.pcs      ? {{(`DATA_WIDTH-`MEM_ADDR_BITS){1'b0}}, pcPlus1}
                  : ctrl.memToReg ? rdata : aluResult;

    // Requests hold steady until granted since ir and regs do not move
    always_comb begin
        memReq.en    = 1'b0;
        memReq.we    = 1'b0;
        memReq.addr  = pc;
        memReq.wdata = rdDataB;
        if (state == FETCH) begin
            memReq.en = !irPending;
        end else if (state == MEM) begin
            memReq.en   = 1'b1;
            memReq.we   = ctrl.memWrite;
            memReq.addr = aluResult[`MEM_ADDR_BITS-1:0]; // rs + imm4
        end
    end

    ////////////////////////////////////////
    // Sequencer
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rstN) begin
            state     <= IDLE;
            irPending <= 1'b0;
            pc        <= '0;
            flags     <= '0;
        end else begin
            case (state)
                IDLE: if (start) state <= FETCH;
                FETCH: begin
                    if (irPending) begin
                        ir        <= rdata; // Word from last cycle's grant
                        irPending <= 1'b0;
                        state     <= EXEC;
                    end else if (coreGnt) begin
                        irPending <= 1'b1;
                    end
                end
                EXEC: begin
                    if (ctrl.zEn) flags.z <= aluFlags.z;
                    if (ctrl.nvEn) begin
                        flags.n <= aluFlags.n;
                        flags.v <= aluFlags.v;
                    end
                    if (ctrl.hlt) begin
                        state <= HALT; // PC stays on HLT
                    end else begin
                        pc    <= (ctrl.branch && condTrue) ? branchTarget : pcPlus1;
                        state <= ctrl.memEnable ? MEM : FETCH;
                    end
                end
                MEM:     if (coreGnt) state <= WB;
                WB:      state <= FETCH; // Load data written here
                default: state <= HALT;  // Stay halted until reset
            endcase
        end
    end

    assign halted = (state == HALT);

endmodule

//--- verilog/MemArbiter.sv
module MemArbiter (
    input  CpuBusPkg::memReqS hostReq,
    input  CpuBusPkg::memReqS coreReq,
    output CpuBusPkg::memReqS memReq,
    output logic              coreGnt
);

    ////////////////////////////////////////
    // Fixed priority, host first
    ////////////////////////////////////////
    always_comb begin
        if (hostReq.en) begin
            memReq  = hostReq; // Host owns the port this cycle
            coreGnt = 1'b0;    // Core holds its request
        end else begin
            memReq  = coreReq;
            coreGnt = coreReq.en;
        end
    end

    // No state here
    // A stalled core request simply waits for a free cycle

endmodule

//--- verilog/UnifiedMemory.sv
`include "cpu_macros.svh"

module UnifiedMemory (
    input  logic                   clk,
    input  CpuBusPkg::memReqS      memReq,
    output logic [`DATA_WIDTH-1:0] rdata
);

    // Instructions and data share one array
    logic [`DATA_WIDTH-1:0] mem [1 << `MEM_ADDR_BITS];

    always_ff @(posedge clk) begin
        if (memReq.en) begin
            if (memReq.we) begin
                mem[memReq.addr] <= memReq.wdata; // Write at the edge
            end else begin
                rdata <= mem[memReq.addr];        // Read data next cycle
            end
        end
    end

endmodule

//--- verilog/CpuTop.sv
`include "cpu_macros.svh"

module CpuTop (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   start,
    input  CpuBusPkg::memReqS      hostReq,
    output logic [`DATA_WIDTH-1:0] rdata,
    output logic                   halted
);
    import CpuBusPkg::*;

    memReqS coreReq; // Core side of the arbiter
    memReqS memReq;  // Winning request
    logic   coreGnt;

    CpuCore core (.clk(clk), .rstN(rstN), .start(start), .memReq(coreReq),
                  .coreGnt(coreGnt), .rdata(rdata), .halted(halted));

    MemArbiter arbiter (.hostReq(hostReq), .coreReq(coreReq),
                        .memReq(memReq), .coreGnt(coreGnt));

    // Shared read data goes to both core and host
    UnifiedMemory memory (.clk(clk), .memReq(memReq), .rdata(rdata));

endmodule

//--- testbench/core_checker.sv
module CoreChecker (
    input logic              clk,
    input logic              rstN,
    input logic              halted,
    input CpuBusPkg::memReqS memReq,
    input CpuIsaPkg::instrU  ir
);
    timeunit 1ns;
    timeprecision 1ps;

    import CpuIsaPkg::*;

    ////////////////////////////////////////
    // Core bus and halt rules
    ////////////////////////////////////////
    // Once halted, only reset brings the core back
    haltSticky: assert property (@(posedge clk) (rstN && halted) |=> (halted || !rstN))
        else $error("halted dropped without reset");

    // Memory writes come from SW only
    writeOnlySw: assert property (@(posedge clk) disable iff (!rstN)
        (memReq.en && memReq.we) |-> (ir.rType.op == SW))
        else $error("core write request for opcode %h", ir.rType.op);

    quietAfterReset: assert property (@(posedge clk) !rstN |=> !memReq.en)
        else $error("core request active right after reset"); // IDLE drives no request

endmodule

// Checker sits inside every core instance
bind CpuCore CoreChecker coreChk (
    .clk    (clk),
    .rstN   (rstN),
    .halted (halted),
    .memReq (memReq),
    .ir     (ir)
);

//--- testbench/CpuTb.sv
`include "cpu_macros.svh"

module CpuTb;
    timeunit 1ns;
    timeprecision 1ps;

    import CpuIsaPkg::*;
    import CpuBusPkg::*;

    localparam int MemWords  = 1 << `MEM_ADDR_BITS;
    localparam int HaltLimit = 20000; // Cycles allowed per program
    localparam int DataBase  = 512;   // Readback window start
    localparam int DataCount = 64;

    logic                   clk;
    logic                   rstN;
    logic                   start;
    memReqS                 hostReq;
    logic [`DATA_WIDTH-1:0] rdata;
    logic                   halted;

    logic [`DATA_WIDTH-1:0] refMem [MemWords]; // Expected memory image
    logic [`DATA_WIDTH-1:0] prog [$];
    logic                   cmpValid;          // Compare strobe for the checking process
    logic [`DATA_WIDTH-1:0] cmpExp;
    int                     cmpAddr;
    int                     errors;
    int                     checks;
    int                     seed;
    bit                     timedOut;

    CpuTop DUT (.clk(clk), .rstN(rstN), .start(start), .hostReq(hostReq),
                .rdata(rdata), .halted(halted));

    always #2 clk = ~clk; // 4 ns period

    ////////////////////////////////////////
    // Instruction encoders
    ////////////////////////////////////////
    function automatic logic [15:0] rInstr(opcodeE op, int rd, int rs, int rt);
        return {op, rd[3:0], rs[3:0], rt[3:0]}; // rt doubles as imm4
    endfunction

    function automatic logic [15:0] byteInstr(opcodeE op, int rd, int imm8);
        return {op, rd[3:0], imm8[7:0]};
    endfunction

    function automatic logic [15:0] bInstr(int cond, int offset);
        return {B, cond[2:0], offset[8:0]};
    endfunction

    function automatic logic [15:0] brInstr(int cond, int rs);
        return {BR, cond[2:0], 1'b0, rs[3:0], 4'h0}; // rs sits in bits 7:4
    endfunction

    function automatic logic [15:0] fillWord(int addr);
        logic [9:0] a;
        a = addr[9:0];
        return {a, a[5:0]} ^ 16'hA5C3; // Every address bit matters
    endfunction

    function automatic memReqS readReq(int addr);
        return '{en: 1'b1, we: 1'b0, addr: addr[9:0], wdata: '0};
    endfunction

    function automatic memReqS writeReq(int addr, logic [15:0] data);
        return '{en: 1'b1, we: 1'b1, addr: addr[9:0], wdata: data};
    endfunction

    task automatic emit(logic [15:0] word);
        prog.push_back(word);
    endtask

    ////////////////////////////////////////
    // ISA reference model
    ////////////////////////////////////////
    // Runs refMem from PC 0 until HLT and counts the instructions
    function automatic int runModel();
        logic [15:0]       r [16];
        logic [15:0]       ins;
        logic [15:0]       a;
        logic [15:0]       b;
        logic [15:0]       res;
        logic [15:0]       imm;
        logic [9:0]        pc;
        logic [9:0]        addr;
        logic              z;
        logic              n;
        logic              v;
        logic              take;
        logic signed [4:0] lane;
        opcodeE            op;
        int                rd;
        int                rs;
        int                rt;
        int                steps;
        bit                done;
        for (int i = 0; i < 16; i++) r[i] = '0;
        pc = '0;
        {z, n, v} = 3'b000;
        steps = 0;
        done = 0;
        while (!done && steps < HaltLimit) begin
            ins = refMem[pc];
            op = opcodeE'(ins[15:12]);
            rd = ins[11:8];
            rs = ins[7:4];
            rt = ins[3:0];
            a = r[rs];
            b = r[rt];
            imm = {{12{ins[3]}}, ins[3:0]}; // Signed imm4
            res = '0;
            steps++;
            case (op)
                ADD, SUB: begin
                    res = (op == ADD) ? a + b : a - b;
                    v = (op == ADD) ? (a[15] == b[15]) && (res[15] != a[15])
                                    : (a[15] != b[15]) && (res[15] != a[15]);
                    z = (res == 0);
                    n = res[15];
                end
                XOR: begin
                    res = a ^ b;
                    z = (res == 0);
                end
                RED: res = {{8{a[15]}}, a[15:8]} + {{8{a[7]}}, a[7:0]}
                         + {{8{b[15]}}, b[15:8]} + {{8{b[7]}}, b[7:0]};
                SLL, SRA, ROR: begin
                    if (op == SLL) res = a << rt;
                    else if (op == SRA) res = $signed(a) >>> rt;
                    else res = (a >> rt) | (a << (16 - rt));
                    z = (res == 0);
                end
                PADDSB: begin
                    for (int i = 0; i < 4; i++) begin
                        lane = $signed({a[4*i+3], a[4*i +: 4]}) + $signed({b[4*i+3], b[4*i +: 4]});
                        if (lane > 7) res[4*i +: 4] = 4'h7;       // Saturate up
                        else if (lane < -8) res[4*i +: 4] = 4'h8; // Saturate down
                        else res[4*i +: 4] = lane[3:0];
                    end
                end
                LW: begin
                    addr = a + imm;
                    res = refMem[addr];
                end
                SW: begin
                    addr = a + imm;
                    refMem[addr] = r[rd];
                end
                LLB: res = {r[rd][15:8], ins[7:0]};
                LHB: res = {ins[7:0], r[rd][7:0]};
                PCS: res = {6'b0, pc + 10'd1};
                HLT: done = 1;
                default: ; // B and BR below
            endcase
            case (ins[11:9])
                3'd0:    take = !z;
                3'd1:    take = z;
                3'd2:    take = !z && !n;
                3'd3:    take = n;
                3'd4:    take = z || (!n && !v);
                3'd5:    take = z || n;
                3'd6:    take = v;
                default: take = 1'b1;
            endcase
            if (op inside {ADD, SUB, XOR, RED, SLL, SRA, ROR, PADDSB, LW, LLB, LHB, PCS}
                && rd != 0) begin
                r[rd] = res;
            end
            if (!done) begin
                if (op == B && take) pc = pc + 10'd1 + {ins[8], ins[8:0]};
                else if (op == BR && take) pc = a[9:0];
                else pc = pc + 10'd1;
            end
        end
        return steps;
    endfunction

    ////////////////////////////////////////
    // Test programs
    ////////////////////////////////////////
    task automatic buildAluProgram();
        prog.delete();
        emit(byteInstr(LHB, 15, 8'h02)); // r15 = 0x0200
        emit(byteInstr(LLB, 1, 8'hFF));
        emit(byteInstr(LHB, 1, 8'h7F));  // r1 = 0x7FFF
        emit(byteInstr(LLB, 2, 8'h01));
        emit(rInstr(ADD, 3, 1, 2));      // Overflows to 0x8000
        emit(byteInstr(LLB, 4, 8'h11));
        emit(bInstr(6, 1));              // Taken on V
        emit(byteInstr(LLB, 4, 8'h22));
        emit(rInstr(PCS, 5, 0, 0));
        emit(rInstr(SUB, 6, 3, 2));      // Overflows back
        emit(rInstr(XOR, 7, 1, 3));
        emit(rInstr(RED, 8, 1, 1));
        emit(rInstr(SLL, 9, 1, 3));
        emit(rInstr(SRA, 10, 3, 4));
        emit(rInstr(ROR, 11, 1, 5));
        emit(byteInstr(LLB, 13, 8'h88));
        emit(byteInstr(LHB, 13, 8'h77));
        emit(rInstr(PADDSB, 12, 13, 13)); // Both saturation directions
        for (int i = 0; i < 8; i++) emit(rInstr(SW, 3 + i, 15, i));
        emit(byteInstr(LLB, 15, 8'h08));
        emit(rInstr(SW, 11, 15, 0));
        emit(rInstr(SW, 12, 15, 1));
        emit(rInstr(HLT, 0, 0, 0));
    endtask

    task automatic buildMemProgram();
        prog.delete();
        emit(byteInstr(LLB, 15, 8'h08));
        emit(byteInstr(LHB, 15, 8'h02)); // Base 0x208
        emit(byteInstr(LLB, 1, 8'h34));
        emit(byteInstr(LHB, 1, 8'h12));
        emit(rInstr(SW, 1, 15, -8));     // Address 512
        emit(byteInstr(LLB, 2, 8'hCD));
        emit(byteInstr(LHB, 2, 8'hAB));
        emit(rInstr(SW, 2, 15, -1));
        emit(rInstr(LW, 3, 15, -8));
        emit(rInstr(LW, 4, 15, -1));
        emit(rInstr(ADD, 5, 3, 4));
        emit(rInstr(SW, 5, 15, 7));
        emit(rInstr(SW, 4, 15, 3));
        emit(rInstr(LW, 6, 15, 5));      // Fill word
        emit(rInstr(SW, 6, 15, 4));
        emit(rInstr(HLT, 0, 0, 0));
    endtask

    task automatic buildBranchProgram();
        int mark;
        int target;
        prog.delete();
        mark = 0;
        emit(byteInstr(LHB, 15, 8'h02));
        emit(byteInstr(LLB, 1, 8'hFF));
        emit(byteInstr(LHB, 1, 8'h7F));
        emit(byteInstr(LLB, 2, 8'h01));
        for (int setup = 0; setup < 3; setup++) begin
            if (setup == 0) emit(rInstr(SUB, 3, 0, 0));      // Z only
            else if (setup == 1) emit(rInstr(ADD, 3, 1, 2)); // N and V
            else emit(rInstr(ADD, 3, 2, 2));                 // All clear
            for (int cond = 0; cond < 8; cond++) begin
                emit(byteInstr(LLB, 4, 8'h01)); // Marker stays 1 when taken
                emit(bInstr(cond, 1));
                emit(byteInstr(LLB, 4, 8'h00));
                emit(byteInstr(LLB, 15, mark));
                emit(rInstr(SW, 4, 15, 0));
                mark++;
            end
        end
        emit(rInstr(SUB, 3, 0, 0));
        for (int k = 0; k < 8; k++) begin
            emit(byteInstr(LLB, 4, 8'h01));
            target = prog.size() + 4;
            emit(byteInstr(LLB, 6, target[7:0]));
            emit(byteInstr(LHB, 6, target[15:8]));
            emit(brInstr(k, 6)); // Z set so codes 0, 2, 3 and 6 fall through
            emit(byteInstr(LLB, 4, 8'h00));
            emit(byteInstr(LLB, 15, mark));
            emit(rInstr(SW, 4, 15, 0));
            mark++;
        end
        emit(rInstr(HLT, 0, 0, 0));
    endtask

    task automatic buildRandomProgram();
        opcodeE ops [10];
        int     sel;
        ops = '{ADD, SUB, XOR, RED, SLL, SRA, ROR, PADDSB, LLB, LHB};
        prog.delete();
        for (int i = 0; i < 40; i++) begin
            sel = $unsigned($random(seed)) % 10;
            emit(byteInstr(ops[sel], 1 + ($unsigned($random(seed)) % 14), $random(seed)));
        end
        emit(byteInstr(LLB, 15, 8'h00));
        emit(byteInstr(LHB, 15, 8'h02));
        for (int i = 0; i < 15; i++) begin
            if (i == 8) emit(byteInstr(LLB, 15, 8'h08)); // Next block of eight
            emit(rInstr(SW, i, 15, i % 8));
        end
        emit(rInstr(HLT, 0, 0, 0));
    endtask

    ////////////////////////////////////////
    // Run control
    ////////////////////////////////////////
    task automatic applyReset();
        @(posedge clk);
        rstN <= 1'b0;
        repeat (2) @(posedge clk);
        rstN <= 1'b1;
    endtask

    // Whole memory goes in so loads never see unknown words
    task automatic loadMemory();
        for (int a = 0; a < MemWords; a++) begin
            refMem[a] = (a < prog.size()) ? prog[a] : fillWord(a);
            @(posedge clk);
            hostReq <= writeReq(a, refMem[a]);
        end
        @(posedge clk);
        hostReq <= '0;
    endtask

    task automatic waitHalted(bit contention);
        int cycles;
        cycles = 0;
        while (!halted && cycles < HaltLimit) begin
            @(posedge clk);
            if (contention) begin // Host steals random cycles
                hostReq <= $random(seed) & 1 ? readReq(900 + ($unsigned($random(seed)) % 100))
                                             : '0;
            end
            @(negedge clk);
            cycles++;
        end
        @(posedge clk);
        hostReq <= '0;
        if (!halted) begin
            $display("Timeout: core did not halt within %0d cycles", cycles);
            errors++;
            timedOut = 1;
        end
    endtask

    task automatic readBack();
        for (int a = DataBase; a < DataBase + DataCount; a++) begin
            @(posedge clk);
            hostReq  <= readReq(a);
            cmpValid <= 1'b0;
            @(posedge clk);
            hostReq  <= '0;
            cmpValid <= 1'b1; // rdata valid one cycle after the grant
            cmpExp   <= refMem[a];
            cmpAddr  <= a;
        end
        @(posedge clk);
        cmpValid <= 1'b0;
    endtask

    task automatic runTest(string name, bit contention);
        int steps;
        $display("Running %s", name);
        applyReset();
        loadMemory();
        steps = runModel();
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        waitHalted(contention);
        if (!timedOut) readBack();
        $display("  %s done, model ran %0d instructions", name, steps);
    endtask

    // Comparing process samples mid-cycle
    always @(negedge clk) begin
        if (cmpValid) begin
            checks++;
            if (rdata !== cmpExp) begin
                $display("[FAIL] %0t rdata[%0d] expected %h got %h", $time, cmpAddr,
                         cmpExp, rdata);
                errors++;
            end
        end
    end

    initial begin
        clk      = 1'b0;
        rstN     = 1'b0;
        start    = 1'b0;
        hostReq  = '0;
        cmpValid = 1'b0;
        cmpExp   = '0;
        cmpAddr  = 0;
        errors   = 0;
        checks   = 0;
        timedOut = 0;
        seed     = 66528;

        buildAluProgram();
        runTest("ALU operations and flags", 0);
        if (!timedOut) begin
            buildMemProgram();
            runTest("loads and stores", 0);
        end
        if (!timedOut) begin
            buildBranchProgram();
            runTest("branches", 0);
        end
        if (!timedOut) begin
            buildAluProgram();
            runTest("host contention", 1);
        end
        if (!timedOut) begin
            buildRandomProgram();
            runTest("random program", 0);
        end

        $display("Errors: %0d in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+common
common/CpuIsaPkg.sv
common/CpuBusPkg.sv
core/ControlUnit.sv
core/RegisterFile.sv
core/Alu.sv
core/CpuCore.sv
verilog/MemArbiter.sv
verilog/UnifiedMemory.sv
verilog/CpuTop.sv
testbench/core_checker.sv
testbench/CpuTb.sv
